//--- score_hud.f
logic/hud_pkg.sv
logic/hud_score_regs.sv
logic/coin_bcd.sv
logic/hud_char_map.sv
logic/hud_row_scan.sv
logic/score_hud_top.sv
bench/hud_char_map_sva.sv
bench/score_hud_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the score HUD testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal --top-module score_hud_tb \
    -f score_hud.f -o score_hud_sim && ./obj_dir/score_hud_sim; } 2>&1 | tee sim.log
grep -q "^=== PASS ===$" sim.log && echo "score_hud: simulation passed" \
  || { echo "score_hud: simulation failed"; exit 1; }

//--- bench/score_hud_tb.sv
// ==========================================================================
// Score HUD testbench
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module score_hud_tb
  import hud_pkg::*;
();

  localparam int ROW_LEN      = 72;
  localparam int ROWS         = 9;
  localparam int BUSY_TIMEOUT = 100;
  localparam int SCAN_TIMEOUT = ROW_LEN + 20;
  localparam int BUSY_CYCLES  = 13;

  // Event rows: coin count is base plus a random value below span
  localparam int NEW_GAME  [ROWS] = '{0, 0, 0, 0, 0, 1, 0, 1, 0};
  localparam int COIN_BASE [ROWS] = '{0, 1, 300, 600, 5, 0, 1000, 0, 50};
  localparam int COIN_SPAN [ROWS] = '{1, 20, 200, 100, 10, 10, 100, 1, 400};
  localparam int UP_CNT    [ROWS] = '{0, 2, 0, 9, 3, 0, 4, 0, 0};
  localparam int DOWN_CNT  [ROWS] = '{0, 0, 1, 0, 3, 5, 2, 0, 1};
  localparam int LEVEL_CNT [ROWS] = '{0, 3, 0, 9, 0, 2, 0, 0, 1};
  localparam int EXP_LIVES [ROWS] = '{3, 5, 4, 9, 9, 0, 2, 3, 2};
  localparam int EXP_LEVEL [ROWS] = '{1, 4, 4, 9, 9, 3, 3, 1, 2};

  logic       clk;
  logic       rst_n;
  logic       coin_strobe;
  logic       life_up;
  logic       life_down;
  logic       level_up;
  logic       new_game;
  logic       row_start;
  col_t       char_xy;
  char_code_t char_code;
  logic       code_valid;
  logic       last;
  logic       digits_busy;
  digit_t     lives;
  digit_t     level;
  int         mismatch_count;
  int         other_count;
  int         busy_run;
  int         busy_pulses;

  score_hud_top #(
    .ROW_LEN (ROW_LEN)
  ) i_score_hud_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .coin_strobe (coin_strobe),
    .life_up     (life_up),
    .life_down   (life_down),
    .level_up    (level_up),
    .new_game    (new_game),
    .row_start   (row_start),
    .char_xy     (char_xy),
    .char_code   (char_code),
    .code_valid  (code_valid),
    .last        (last),
    .digits_busy (digits_busy),
    .lives       (lives),
    .level       (level)
  );

  bind hud_char_map hud_char_map_sva i_hud_char_map_sva (
    .clk       (score_hud_tb.clk),
    .rst_n     (score_hud_tb.rst_n),
    .char_xy   (char_xy),
    .char_code (char_code)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Overall limit in case a wait loop is broken
  initial begin
    #500_000;
    $display("watchdog expired before the test finished");
    $display("=== FAIL ===");
    $finish;
  end

  // One load cycle and 12 shift cycles per conversion
  always @(negedge clk) begin
    if (digits_busy) begin
      busy_run++;
    end else if (busy_run != 0) begin
      if (busy_run != BUSY_CYCLES) begin
        $display("digits_busy stayed high for %0d cycles instead of %0d",
                 busy_run, BUSY_CYCLES);
        other_count++;
      end
      busy_pulses++;
      busy_run = 0;
    end
  end

  task automatic check_code(input string name, input char_code_t got, input char_code_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_col(input string name, input col_t got, input col_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_digit(input string name, input digit_t got, input digit_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%01h, expected 0x%01h", name, got, exp);
      mismatch_count++;
    end
  endtask

  // Reference status line
  function automatic char_code_t expect_code(input int col, input int lv, input int lvl,
                                             input int coins);
    char_code_t code;
    code = 8'hFF;
    if (col < 'h07) begin
      code = char_code_t'('h0A + col);
    end else if (col == 'h07) begin
      code = char_code_t'(lv);
    end else if (col < 'h20) begin
      code = 8'h0F;
    end else if (col < 'h26) begin
      case (col)
        'h20:    code = 8'h11;
        'h21:    code = 8'h0F;
        'h22:    code = 8'h10;
        'h23:    code = char_code_t'(coins / 100);
        'h24:    code = char_code_t'((coins / 10) % 10);
        default: code = char_code_t'(coins % 10);
      endcase
    end else if (col < 'h3E) begin
      code = 8'h0F;
    end else if (col < 'h45) begin
      case (col)
        'h3E:    code = 8'h12;
        'h3F:    code = 8'h13;
        'h40:    code = 8'h14;
        'h41:    code = 8'h13;
        'h42:    code = 8'h12;
        'h43:    code = 8'h0F;
        default: code = char_code_t'(lvl);
      endcase
    end
    return code;
  endfunction

  task automatic apply_events(input int r, input int coin_cnt);
    int n;
    n = coin_cnt;
    if (UP_CNT[r] > n) n = UP_CNT[r];
    if (DOWN_CNT[r] > n) n = DOWN_CNT[r];
    if (LEVEL_CNT[r] > n) n = LEVEL_CNT[r];
    if (NEW_GAME[r] != 0) begin
      @(posedge clk);
      new_game <= 1'b1;
    end
    // Strobes overlap, so up and down share cycles
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      new_game    <= 1'b0;
      coin_strobe <= (i < coin_cnt);
      life_up     <= (i < UP_CNT[r]);
      life_down   <= (i < DOWN_CNT[r]);
      level_up    <= (i < LEVEL_CNT[r]);
    end
    @(posedge clk);
    new_game    <= 1'b0;
    coin_strobe <= 1'b0;
    life_up     <= 1'b0;
    life_down   <= 1'b0;
    level_up    <= 1'b0;
  endtask

  // Busy low on two samples in a row means no restart is pending
  task automatic wait_digits();
    int cyc;
    int low_run;
    cyc = 0;
    low_run = 0;
    while (low_run < 2 && cyc < BUSY_TIMEOUT) begin
      @(negedge clk);
      cyc++;
      low_run = digits_busy ? 0 : low_run + 1;
    end
    if (low_run < 2) begin
      $display("timeout: digits_busy did not fall within %0d cycles", BUSY_TIMEOUT);
      other_count++;
    end
  endtask

  task automatic scan_row(input int lv, input int lvl, input int coins);
    int seen;
    int cyc;
    bit done;
    seen = 0;
    cyc = 0;
    done = 1'b0;
    @(posedge clk);
    row_start <= 1'b1;
    @(posedge clk);
    row_start <= 1'b0;
    while (!done && cyc < SCAN_TIMEOUT) begin
      @(negedge clk);
      cyc++;
      if (code_valid) begin
        check_col($sformatf("char_xy at code %0d", seen), char_xy, col_t'(seen));
        check_code($sformatf("char_code at column 0x%02h", seen), char_code,
                   expect_code(seen, lv, lvl, coins));
        if (last && seen != ROW_LEN - 1) begin
          $display("last came early at column %0d", seen);
          other_count++;
        end else if (!last && seen == ROW_LEN - 1) begin
          $display("last missing on the final column");
          other_count++;
        end
        done = last || (seen == ROW_LEN - 1);
        seen++;
      end else begin
        $display("code_valid missing after %0d of %0d codes", seen, ROW_LEN);
        other_count++;
        done = 1'b1;
      end
      @(posedge clk);
      // Extra start pulse in the middle of the row
      row_start <= (cyc == 6);
    end
    if (!done) begin
      $display("timeout: row did not end within %0d cycles", SCAN_TIMEOUT);
      other_count++;
    end
    @(negedge clk);
    if (code_valid) begin
      $display("code_valid still high after the final column");
      other_count++;
    end
  endtask

  initial begin
    int coin_cnt;
    int exp_coins;
    rst_n       <= 1'b0;
    coin_strobe <= 1'b0;
    life_up     <= 1'b0;
    life_down   <= 1'b0;
    level_up    <= 1'b0;
    new_game    <= 1'b0;
    row_start   <= 1'b0;
    mismatch_count = 0;
    other_count = 0;
    exp_coins = 0;
    void'($urandom(32'ha3b3_327b));
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int r = 0; r < ROWS; r++) begin
      coin_cnt = COIN_BASE[r] + int'($urandom % COIN_SPAN[r]);
      if (NEW_GAME[r] != 0) exp_coins = 0;
      exp_coins = (exp_coins + coin_cnt > 999) ? 999 : exp_coins + coin_cnt;
      apply_events(r, coin_cnt);
      wait_digits();
      check_digit("lives", lives, digit_t'(EXP_LIVES[r]));
      check_digit("level", level, digit_t'(EXP_LEVEL[r]));
      scan_row(EXP_LIVES[r], EXP_LEVEL[r], exp_coins);
    end
    if (busy_pulses == 0) begin
      $display("digits_busy never went high while the coin count changed");
      other_count++;
    end
    $display("errors: %0d mismatch, %0d other", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/hud_char_map_sva.sv
// ==========================================================================
// Character map assertions
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module hud_char_map_sva
  import hud_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input col_t       char_xy,
  input char_code_t char_code
);

  // Nothing exists past the level digit
  beyond_line: assert property (@(posedge clk) disable iff (!rst_n)
    (char_xy > 8'h44) |-> (char_code == 8'hFF))
    else $error("column 0x%02h beyond the line gave code 0x%02h", char_xy, char_code);

  // Coin digits are always shown as a decimal digit
  coin_digit: assert property (@(posedge clk) disable iff (!rst_n)
    (char_xy >= 8'h23 && char_xy <= 8'h25) |-> (char_code <= 8'h09))
    else $error("coin column 0x%02h gave non-digit code 0x%02h", char_xy, char_code);

  label_code: assert property (@(posedge clk) disable iff (!rst_n)
    (char_xy <= 8'h06) |-> (char_code == 8'h0A + char_xy))
    else $error("label column 0x%02h gave code 0x%02h", char_xy, char_code);

endmodule

`default_nettype wire

//--- logic/score_hud_top.sv
// ==========================================================================
// Score HUD top level
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module score_hud_top
  import hud_pkg::*;
#(
  parameter int ROW_LEN = 69
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       coin_strobe,
  input  logic       life_up,
  input  logic       life_down,
  input  logic       level_up,
  input  logic       new_game,
  input  logic       row_start,
  output col_t       char_xy,
  output char_code_t char_code,
  output logic       code_valid,
  output logic       last,
  output logic       digits_busy,
  output digit_t     lives,
  output digit_t     level
);

  coins_t     coins;
  digit_t     coin_hi;
  digit_t     coin_mid;
  digit_t     coin_lo;
  col_t       map_xy;
  char_code_t map_code;

  hud_score_regs i_hud_score_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .coin_strobe (coin_strobe),
    .life_up     (life_up),
    .life_down   (life_down),
    .level_up    (level_up),
    .new_game    (new_game),
    .lives       (lives),
    .level       (level),
    .coins       (coins)
  );

  coin_bcd i_coin_bcd (
    .clk      (clk),
    .rst_n    (rst_n),
    .coins    (coins),
    .coin_hi  (coin_hi),
    .coin_mid (coin_mid),
    .coin_lo  (coin_lo),
    .busy     (digits_busy)
  );

  hud_char_map i_hud_char_map (
    .char_xy   (map_xy),
    .lives     (lives),
    .level     (level),
    .coin_hi   (coin_hi),
    .coin_mid  (coin_mid),
    .coin_lo   (coin_lo),
    .char_code (map_code)
  );

  hud_row_scan #(
    .ROW_LEN (ROW_LEN)
  ) i_hud_row_scan (
    .clk        (clk),
    .rst_n      (rst_n),
    .row_start  (row_start),
    .map_code   (map_code),
    .map_xy     (map_xy),
    .char_xy    (char_xy),
    .char_code  (char_code),
    .code_valid (code_valid),
    .last       (last)
  );

endmodule

`default_nettype wire

//--- logic/hud_row_scan.sv
// ==========================================================================
// Status line row scanner
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module hud_row_scan
  import hud_pkg::*;
#(
  parameter int ROW_LEN = 69
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       row_start,
  input  char_code_t map_code,
  output col_t       map_xy,
  output col_t       char_xy,
  output char_code_t char_code,
  output logic       code_valid,
  output logic       last
);

  localparam col_t LAST_COL = col_t'(ROW_LEN - 1);

  logic active;
  col_t col;
  logic fire;

  // Column 0 is looked up in the same cycle as row_start
  assign fire   = active || row_start;
  assign map_xy = active ? col : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active     <= 1'b0;
      col        <= '0;
      code_valid <= 1'b0;
      last       <= 1'b0;
    end else begin
      code_valid <= fire;
      last       <= fire && (map_xy == LAST_COL);
      if (fire) begin
        active <= (map_xy != LAST_COL);
        col    <= map_xy + 8'd1;
      end
    end
  end

  // Code and column are captured on the same edge
  always_ff @(posedge clk) begin
    if (fire) begin
      char_code <= map_code;
      char_xy   <= map_xy;
    end
  end

endmodule

`default_nettype wire

//--- logic/hud_char_map.sv
// ==========================================================================
// Status line character map
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module hud_char_map
  import hud_pkg::*;
(
  input  col_t       char_xy,
  input  digit_t     lives,
  input  digit_t     level,
  input  digit_t     coin_hi,
  input  digit_t     coin_mid,
  input  digit_t     coin_lo,
  output char_code_t char_code
);

  // Columns around the coin counter
  localparam col_t COL_COIN_GAP = COL_COIN_ICON + 8'd1;
  localparam col_t COL_CROSS    = COL_COIN_ICON + 8'd2;
  localparam col_t COL_COIN_MID = COL_COIN_HI + 8'd1;
  localparam col_t COL_COIN_LO  = COL_COIN_HI + 8'd2;

  col_t tail_off;

  function automatic char_code_t digit_code(input digit_t d);
    return (d > DIGIT_MAX) ? CODE_BAD_DIGIT : char_code_t'(d);
  endfunction

  assign tail_off = char_xy - COL_TAIL;

  always_comb begin
    char_code = CODE_NONE;
    if (char_xy < COL_LIVES) begin
      char_code = CODE_LABEL_BASE + char_xy;
    end else if (char_xy == COL_LIVES) begin
      char_code = digit_code(lives);
    end else if (char_xy < COL_COIN_ICON) begin
      char_code = CODE_BLANK;
    end else if (char_xy == COL_COIN_ICON) begin
      char_code = CODE_COIN_ICON;
    end else if (char_xy == COL_COIN_GAP) begin
      char_code = CODE_BLANK;
    end else if (char_xy == COL_CROSS) begin
      char_code = CODE_CROSS;
    end else if (char_xy == COL_COIN_HI) begin
      char_code = digit_code(coin_hi);
    end else if (char_xy == COL_COIN_MID) begin
      char_code = digit_code(coin_mid);
    end else if (char_xy == COL_COIN_LO) begin
      char_code = digit_code(coin_lo);
    end else if (char_xy < COL_TAIL) begin
      char_code = CODE_BLANK;
    end else if (char_xy < COL_LEVEL) begin
      // World label, symmetric around its middle tile
      case (tail_off)
        8'd0:    char_code = CODE_WORLD_A;
        8'd1:    char_code = CODE_WORLD_B;
        8'd2:    char_code = CODE_WORLD_C;
        8'd3:    char_code = CODE_WORLD_B;
        8'd4:    char_code = CODE_WORLD_A;
        default: char_code = CODE_BLANK;
      endcase
    end else if (char_xy == COL_LEVEL) begin
      char_code = digit_code(level);
    end
  end

endmodule

`default_nettype wire

//--- logic/coin_bcd.sv
// ==========================================================================
// Coin count to decimal converter
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module coin_bcd
  import hud_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  coins_t coins,
  output digit_t coin_hi,
  output digit_t coin_mid,
  output digit_t coin_lo,
  output logic   busy
);

  localparam int DIGITS  = 3;
  localparam int BCD_W   = DIGITS * DIGIT_W;
  localparam int SHIFT_W = BCD_W + COINS_W;
  localparam int STEP_W  = 4;
  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(COINS_W);

  logic [SHIFT_W-1:0] shift_q;
  logic [SHIFT_W-1:0] shift_nxt;
  logic [STEP_W-1:0]  step;
  coins_t             last_q;

  // One double-dabble step: adjust each digit, then shift left
  function automatic logic [SHIFT_W-1:0] dabble(input logic [SHIFT_W-1:0] v);
    logic [SHIFT_W-1:0] r;
    r = v;
    for (int i = 0; i < DIGITS; i++) begin
      if (r[COINS_W + DIGIT_W*i +: DIGIT_W] > 4'd4) begin
        r[COINS_W + DIGIT_W*i +: DIGIT_W] = r[COINS_W + DIGIT_W*i +: DIGIT_W] + 4'd3;
      end
    end
    return r << 1;
  endfunction

  assign shift_nxt = dabble(shift_q);

  // Step 0 loads, steps 1 to 12 shift
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      step     <= '0;
      last_q   <= '0;
      coin_hi  <= '0;
      coin_mid <= '0;
      coin_lo  <= '0;
    end else if (!busy) begin
      if (coins != last_q) begin
        busy   <= 1'b1;
        step   <= '0;
        last_q <= coins;
      end
    end else begin
      step <= step + 1'b1;
      if (step == LAST_STEP) begin
        // All three digits change together
        busy     <= 1'b0;
        coin_hi  <= shift_nxt[SHIFT_W-1 -: DIGIT_W];
        coin_mid <= shift_nxt[SHIFT_W-DIGIT_W-1 -: DIGIT_W];
        coin_lo  <= shift_nxt[COINS_W +: DIGIT_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      if (step == '0) begin
        shift_q <= {{BCD_W{1'b0}}, last_q};
      end else begin
        shift_q <= shift_nxt;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/hud_score_regs.sv
// ==========================================================================
// Game counter registers
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module hud_score_regs
  import hud_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   coin_strobe,
  input  logic   life_up,
  input  logic   life_down,
  input  logic   level_up,
  input  logic   new_game,
  output digit_t lives,
  output digit_t level,
  output coins_t coins
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lives <= LIVES_START;
      level <= LEVEL_START;
      coins <= '0;
    end else if (new_game) begin
      // New game overrides every other event in the same cycle
      lives <= LIVES_START;
      level <= LEVEL_START;
      coins <= '0;
    end else begin
      if (coin_strobe && (coins < COINS_MAX)) begin
        coins <= coins + 12'd1;
      end

      // Up and down together cancel out
      if (life_up && !life_down) begin
        if (lives < DIGIT_MAX) begin
          lives <= lives + 4'd1;
        end
      end else if (life_down && !life_up) begin
        if (lives != '0) begin
          lives <= lives - 4'd1;
        end
      end

      if (level_up && (level < DIGIT_MAX)) begin
        level <= level + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/hud_pkg.sv
// ==========================================================================
// Score HUD shared definitions
// ==========================================================================
`default_nettype none

package hud_pkg;

  // Field widths
  localparam int CODE_W  = 8;
  localparam int COL_W   = 8;
  localparam int DIGIT_W = 4;
  localparam int COINS_W = 12;

  typedef logic [CODE_W-1:0]  char_code_t;
  typedef logic [COL_W-1:0]   col_t;
  typedef logic [DIGIT_W-1:0] digit_t;
  typedef logic [COINS_W-1:0] coins_t;

  // Fixed columns of the status line
  localparam col_t COL_LIVES     = 8'h07;
  localparam col_t COL_COIN_ICON = 8'h20;
  localparam col_t COL_COIN_HI   = 8'h23;
  localparam col_t COL_TAIL      = 8'h3E;
  localparam col_t COL_LEVEL     = 8'h44;

  // Tile codes
  localparam char_code_t CODE_BAD_DIGIT  = 8'h00;
  localparam char_code_t CODE_LABEL_BASE = 8'h0A;
  localparam char_code_t CODE_BLANK      = 8'h0F;
  localparam char_code_t CODE_CROSS      = 8'h10;
  localparam char_code_t CODE_COIN_ICON  = 8'h11;
  localparam char_code_t CODE_WORLD_A    = 8'h12;
  localparam char_code_t CODE_WORLD_B    = 8'h13;
  localparam char_code_t CODE_WORLD_C    = 8'h14;
  localparam char_code_t CODE_NONE       = 8'hFF;

  // Start values and saturation limits
  localparam digit_t LIVES_START = 4'd3;
  localparam digit_t LEVEL_START = 4'd1;
  localparam digit_t DIGIT_MAX   = 4'd9;
  localparam coins_t COINS_MAX   = 12'd999;

endpackage

`default_nettype wire
